// File: src/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // Width of one stream word on both the enqueue and the dequeue side
    localparam int DATA_BITS = 16;
    typedef logic [DATA_BITS-1:0] data_t;

    // Largest value a stream word can carry
    // Scaled results above it are clamped here
    localparam data_t DATA_MAX = '1;

    // Unsigned fixed-point gain, the binary point sits GAIN_FRAC_BITS from the right
    localparam int GAIN_BITS = 8;
    typedef logic [GAIN_BITS-1:0] gain_t;

    // With 4 fractional bits a gain of 16 means 1.0
    localparam int GAIN_FRAC_BITS_DEFAULT = 4;

    // Intermediate wide enough for word times gain plus offset, including the carry of the add
    typedef logic [DATA_BITS+GAIN_BITS:0] wide_t;

    // Saturation counter that sticks at its maximum
    localparam int SAT_COUNT_BITS = 16;
    typedef logic [SAT_COUNT_BITS-1:0] sat_count_t;
    localparam sat_count_t SAT_COUNT_MAX = '1;

endpackage

`default_nettype wire

// File: src/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

    // Four registers, so two address bits are enough
    localparam int CFG_ADDR_BITS = 2;
    typedef logic [CFG_ADDR_BITS-1:0] cfg_addr_t;

    // Register data is as wide as a stream word
    localparam int CFG_WORD_BITS = 16;
    typedef logic [CFG_WORD_BITS-1:0] cfg_word_t;

    // Control register, only the enable bit is implemented
    localparam cfg_addr_t ADDR_CTRL = 2'd0;
    localparam int CTRL_ENABLE_BIT = 0;

    // Gain lives in the low bits of its register
    localparam cfg_addr_t ADDR_GAIN = 2'd1;

    // Offset uses the whole register
    localparam cfg_addr_t ADDR_OFFSET = 2'd2;

    // Reads return the saturation count and any write clears it
    localparam cfg_addr_t ADDR_SAT_COUNT = 2'd3;

endpackage

`default_nettype wire

// File: src/fifo2.sv
`timescale 1ns/100ps
`default_nettype none

module fifo2
  #(
    parameter int N_DATA_BITS = 32
    )
   (
    input  logic clk,
    input  logic reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
    );

    // Bit 1 flags the output slot and bit 0 the holding slot
    logic [1:0] valid;
    logic [N_DATA_BITS-1:0] data [0:1];

    // The output slot can take a word when it is empty or drained this cycle
    logic out_slot_open;

    // The holding slot is only ever filled while the output slot is full,
    // so a busy holding slot means both entries are taken
    assign not_full = !valid[0];
    assign not_empty = valid[1];
    assign first = data[1];

    assign out_slot_open = !valid[1] || deq_en;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 2'b00;
        end
        else if (out_slot_open)
        begin
            // Either the held word moves forward or a new word goes straight out
            // Both cannot happen since a busy holding slot blocks enqueue
            valid[1] <= valid[0] || enq_en;
            valid[0] <= 1'b0;
        end
        else
        begin
            // Output slot is stalled, a new word parks in the holding slot
            valid[0] <= valid[0] || enq_en;
        end
    end

    // Payload storage follows the valid bits and needs no reset
    always_ff @(posedge clk)
    begin
        if (out_slot_open)
        begin
            data[1] <= valid[0] ? data[0] : enq_data;
        end

        // Capture speculatively while the holding slot is free
        if (!valid[0])
        begin
            data[0] <= enq_data;
        end
    end

    // The writer must look at not_full before enqueueing
    enq_full_a: assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full)
        else $error("%m: enqueue to a full FIFO");

    // The reader must look at not_empty before dequeueing
    deq_empty_a: assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty)
        else $error("%m: dequeue from an empty FIFO");

endmodule

`default_nettype wire

// File: src/scale_stage.sv
`timescale 1ns/100ps
`default_nettype none

module scale_stage
  #(
    parameter int GAIN_FRAC_BITS = stream_pkg::GAIN_FRAC_BITS_DEFAULT
    )
   (
    input  logic clk,
    input  logic reset,

    // Head of the input FIFO
    input  stream_pkg::data_t in_first,
    input  logic in_not_empty,
    output logic in_deq_en,

    // Tail of the output FIFO
    output stream_pkg::data_t out_data,
    output logic out_enq_en,
    input  logic out_not_full,

    // Settings from the register block
    input  logic enable,
    input  stream_pkg::gain_t gain,
    input  stream_pkg::data_t offset,
    input  logic sat_clear,
    output stream_pkg::sat_count_t sat_count
    );

    import stream_pkg::*;

    wide_t product;
    wide_t scaled;
    logic saturated;
    logic transfer;

    // A word moves when one is waiting and there is room behind us
    // Dequeue and enqueue always happen in the same cycle
    assign transfer = in_not_empty && out_not_full;
    assign in_deq_en = transfer;
    assign out_enq_en = transfer;

    // Full-width multiply so no product bits are lost before the shift
    assign product = wide_t'(in_first) * wide_t'(gain);

    // Drop the fractional bits of the gain then add the offset
    assign scaled = (product >> GAIN_FRAC_BITS) + wide_t'(offset);

    // Saturation only has meaning while scaling is switched on
    assign saturated = enable && (scaled > wide_t'(DATA_MAX));

    always_comb
    begin
        if (!enable)
        begin
            // Bypass lets the word through untouched
            out_data = in_first;
        end
        else if (saturated)
        begin
            out_data = DATA_MAX;
        end
        else
        begin
            out_data = data_t'(scaled);
        end
    end

    // Count clamped words that actually left the stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sat_count <= '0;
        end
        else if (sat_clear)
        begin
            // A clear wins over a count in the same cycle
            sat_count <= '0;
        end
        else if (transfer && saturated && (sat_count != SAT_COUNT_MAX))
        begin
            sat_count <= sat_count + 1'b1;
        end
    end

    // A word waiting at the head of the input FIFO must be fully defined
    head_known_a: assert property (@(posedge clk) disable iff (reset)
        in_not_empty |-> !$isunknown(in_first))
        else $error("%m: undefined word at the head of the input FIFO");

endmodule

`default_nettype wire

// File: src/scale_cfg.sv
`timescale 1ns/100ps
`default_nettype none

module scale_cfg
  #(
    parameter int GAIN_FRAC_BITS = stream_pkg::GAIN_FRAC_BITS_DEFAULT
    )
   (
    input  logic clk,
    input  logic reset,

    // Four-phase host port
    input  logic cfg_req,
    input  logic cfg_we,
    input  cfg_pkg::cfg_addr_t cfg_addr,
    input  cfg_pkg::cfg_word_t cfg_wdata,
    output logic cfg_ack,
    output cfg_pkg::cfg_word_t cfg_rdata,

    // Settings toward the scaling stage
    output logic enable,
    output stream_pkg::gain_t gain,
    output stream_pkg::data_t offset,
    output logic sat_clear,
    input  stream_pkg::sat_count_t sat_count
    );

    import stream_pkg::*;
    import cfg_pkg::*;

    typedef enum logic {IDLE, ACKED} state_t;

    state_t state;
    cfg_word_t read_word;
    logic access;

    // The single access of a request happens on the IDLE to ACKED edge
    assign access = (state == IDLE) && cfg_req;
    assign cfg_ack = (state == ACKED);

    // Bits a register does not implement read back as zero
    always_comb
    begin
        read_word = '0;
        case (cfg_addr)
            ADDR_CTRL:      read_word[CTRL_ENABLE_BIT] = enable;
            ADDR_GAIN:      read_word[GAIN_BITS-1:0] = gain;
            ADDR_OFFSET:    read_word = cfg_word_t'(offset);
            ADDR_SAT_COUNT: read_word = cfg_word_t'(sat_count);
        endcase
    end

    // Ack follows req one edge later in both directions
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:  if (cfg_req) state <= ACKED;
                ACKED: if (!cfg_req) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable <= 1'b0;
            // Unity gain at start-up
            gain <= gain_t'(1 << GAIN_FRAC_BITS);
            offset <= '0;
            sat_clear <= 1'b0;
        end
        else
        begin
            // Clear pulse lasts exactly one cycle per write
            sat_clear <= access && cfg_we && (cfg_addr == ADDR_SAT_COUNT);

            if (access && cfg_we)
            begin
                case (cfg_addr)
                    ADDR_CTRL:   enable <= cfg_wdata[CTRL_ENABLE_BIT];
                    ADDR_GAIN:   gain <= cfg_wdata[GAIN_BITS-1:0];
                    ADDR_OFFSET: offset <= data_t'(cfg_wdata);
                    default:
                    begin
                        // Count register is handled by the clear pulse
                    end
                endcase
            end
        end
    end

    // Read data is sampled once and held for as long as ack stays high
    always_ff @(posedge clk)
    begin
        if (access && !cfg_we)
        begin
            cfg_rdata <= read_word;
        end
    end

    // While a request is up the host keeps its command and write data steady
    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        cfg_req && $past(cfg_req) |-> $stable({cfg_we, cfg_addr, cfg_wdata}))
        else $error("%m: request fields changed while cfg_req was high");

endmodule

`default_nettype wire

// File: src/stream_scaler_top.sv
`timescale 1ns/100ps
`default_nettype none

module stream_scaler_top
  #(
    parameter int GAIN_FRAC_BITS = stream_pkg::GAIN_FRAC_BITS_DEFAULT
    )
   (
    input  logic clk,
    input  logic reset,

    // Stream in
    input  stream_pkg::data_t in_data,
    input  logic in_enq_en,
    output logic in_not_full,

    // Stream out
    output stream_pkg::data_t out_data,
    input  logic out_deq_en,
    output logic out_not_empty,

    // Configuration port
    input  logic cfg_req,
    input  logic cfg_we,
    input  cfg_pkg::cfg_addr_t cfg_addr,
    input  cfg_pkg::cfg_word_t cfg_wdata,
    output logic cfg_ack,
    output cfg_pkg::cfg_word_t cfg_rdata
    );

    import stream_pkg::*;

    // Input FIFO head toward the scaling stage
    data_t in_first;
    logic in_not_empty;
    logic in_deq_en;

    // Scaling stage toward the output FIFO
    data_t scaled_data;
    logic scaled_enq_en;
    logic scaled_not_full;

    // Register block settings and status
    logic enable;
    gain_t gain;
    data_t offset;
    logic sat_clear;
    sat_count_t sat_count;

    fifo2 #(.N_DATA_BITS(DATA_BITS)) fifo_in_i
       (
        .clk,
        .reset,
        .enq_data(in_data),
        .enq_en(in_enq_en),
        .not_full(in_not_full),
        .first(in_first),
        .deq_en(in_deq_en),
        .not_empty(in_not_empty)
        );

    scale_stage #(.GAIN_FRAC_BITS(GAIN_FRAC_BITS)) scale_i
       (
        .clk,
        .reset,
        .in_first,
        .in_not_empty,
        .in_deq_en,
        .out_data(scaled_data),
        .out_enq_en(scaled_enq_en),
        .out_not_full(scaled_not_full),
        .enable,
        .gain,
        .offset,
        .sat_clear,
        .sat_count
        );

    // Output FIFO decouples the stage from the reader's back-pressure
    fifo2 #(.N_DATA_BITS(DATA_BITS)) fifo_out_i
       (
        .clk,
        .reset,
        .enq_data(scaled_data),
        .enq_en(scaled_enq_en),
        .not_full(scaled_not_full),
        .first(out_data),
        .deq_en(out_deq_en),
        .not_empty(out_not_empty)
        );

    scale_cfg #(.GAIN_FRAC_BITS(GAIN_FRAC_BITS)) cfg_i
       (
        .clk,
        .reset,
        .cfg_req,
        .cfg_we,
        .cfg_addr,
        .cfg_wdata,
        .cfg_ack,
        .cfg_rdata,
        .enable,
        .gain,
        .offset,
        .sat_clear,
        .sat_count
        );

endmodule

`default_nettype wire

// File: bench/stream_scaler_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stream_scaler_tb;

    localparam int GAIN_FRAC_BITS = 4;
    // Worst case is about eight cycles per word under random stalls, taken four times over,
    // plus reset and register accesses
    localparam int TOTAL_WORDS = 600;
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 32 + 800;

    logic clk;
    logic reset;
    logic [15:0] in_data;
    logic in_enq_en;
    logic in_not_full;
    logic [15:0] out_data;
    logic out_deq_en;
    logic out_not_empty;
    logic cfg_req;
    logic cfg_we;
    logic [1:0] cfg_addr;
    logic [15:0] cfg_wdata;
    logic cfg_ack;
    logic [15:0] cfg_rdata;

    // Expected output words in arrival order
    logic [15:0] expected_q[$];
    // Shadow copy of the register contents, used by the reference model
    logic cur_enable;
    logic [7:0] cur_gain;
    logic [15:0] cur_offset;
    int expected_sat;
    int errors;
    int test_errors_start;
    int tests_passed;
    int tests_failed;
    int cycles;
    bit drain_random;
    int unsigned seed_val;
    logic [15:0] rd;

    stream_scaler_top #(.GAIN_FRAC_BITS(GAIN_FRAC_BITS)) dut_i
       (
        .clk, .reset, .in_data, .in_enq_en, .in_not_full, .out_data, .out_deq_en,
        .out_not_empty, .cfg_req, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_ack, .cfg_rdata
        );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Returns the saturation flag in bit 16 and the expected word below it
    function automatic logic [16:0] scale_ref(input logic [15:0] word, input logic enable,
                                              input logic [7:0] gain, input logic [15:0] offset,
                                              input int frac);
        logic [31:0] full;
        full = word;
        full = (full * gain) >> frac;
        full = full + offset;
        if (!enable)
            return {1'b0, word};
        else if (full > 32'h0000_FFFF)
            return {1'b1, 16'hFFFF};
        else
            return {1'b0, full[15:0]};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors_start)
        begin
            tests_passed++;
            $display("Test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    // One four-phase cycle, req up until ack, then req down until ack drops
    task automatic cfg_access(input logic we, input logic [1:0] addr, input logic [15:0] data,
                              output logic [15:0] rdata);
        @(negedge clk);
        cfg_we = we;
        cfg_addr = addr;
        cfg_wdata = data;
        cfg_req = 1'b1;
        do @(negedge clk); while (!cfg_ack);
        rdata = cfg_rdata;
        cfg_req = 1'b0;
        do @(negedge clk); while (cfg_ack);
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        cfg_access(1'b1, addr, data, unused);
    endtask

    task automatic cfg_read(input logic [1:0] addr, output logic [15:0] data);
        cfg_access(1'b0, addr, 16'h0000, data);
    endtask

    // Offers count random words; at full rate a word goes in every cycle
    task automatic send_words(input int count, input bit full_rate);
        int sent;
        logic [15:0] word;
        logic [16:0] ref_val;
        sent = 0;
        while (sent < count)
        begin
            @(negedge clk);
            if (full_rate)
                check_value(in_not_full, 1, "in_not_full low during full-rate burst");
            if (in_not_full && (full_rate || ($urandom % 4) != 0))
            begin
                word = $urandom;
                ref_val = scale_ref(word, cur_enable, cur_gain, cur_offset, GAIN_FRAC_BITS);
                expected_q.push_back(ref_val[15:0]);
                if (ref_val[16])
                    expected_sat++;
                in_data = word;
                in_enq_en = 1'b1;
                sent++;
            end
            else
                in_enq_en = 1'b0;
        end
        @(negedge clk);
        in_enq_en = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0)
            @(negedge clk);
    endtask

    // The reader only dequeues while the output FIFO holds a word
    always @(negedge clk)
    begin
        if (reset)
            out_deq_en = 1'b0;
        else if (drain_random)
            out_deq_en = out_not_empty && (($urandom % 2) == 1);
        else
            out_deq_en = out_not_empty;
    end

    // Scoreboard, every output transfer is matched against the head of the queue
    always @(posedge clk)
    begin
        if (!reset && out_deq_en && out_not_empty)
        begin
            if (expected_q.size() == 0)
            begin
                $display("Output word 0x%0h arrived at %0t with none expected", out_data, $time);
                errors++;
            end
            else
                check_value(out_data, expected_q.pop_front(), "output word");
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b1;
        in_data = '0;
        in_enq_en = 1'b0;
        out_deq_en = 1'b0;
        cfg_req = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        cur_enable = 1'b0;
        cur_gain = 8'(1 << GAIN_FRAC_BITS);
        cur_offset = '0;
        expected_sat = 0;
        errors = 0;
        test_errors_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        drain_random = 1'b0;
        seed_val = $urandom(38974);
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Idle handshake outputs and unity gain straight after reset
        @(negedge clk);
        check_value(cfg_ack, 0, "cfg_ack after reset");
        check_value(out_not_empty, 0, "out_not_empty after reset");
        check_value(in_not_full, 1, "in_not_full after reset");
        cfg_read(2'd0, rd);
        check_value(rd, 0, "enable after reset");
        cfg_read(2'd1, rd);
        check_value(rd, 1 << GAIN_FRAC_BITS, "gain after reset");
        cfg_read(2'd2, rd);
        check_value(rd, 0, "offset after reset");
        cfg_read(2'd3, rd);
        check_value(rd, 0, "saturation count after reset");
        end_test("reset_state");

        drain_random = 1'b1;
        send_words(200, 1'b0);
        wait_drain();
        end_test("bypass_backpressure");

        // Gain 0.75 and a small offset keep every result below the clamp
        cur_enable = 1'b1;
        cur_gain = 8'd12;
        cur_offset = 16'd1000;
        cfg_write(2'd0, 16'h0001);
        cfg_write(2'd1, 16'(cur_gain));
        cfg_write(2'd2, cur_offset);
        send_words(200, 1'b0);
        wait_drain();
        cfg_read(2'd3, rd);
        check_value(rd, 0, "saturation count without clamping");
        end_test("scaling");

        // Gain 3.0 plus a large offset clamps roughly two words in three
        cur_gain = 8'h30;
        cur_offset = 16'h1000;
        cfg_write(2'd1, 16'(cur_gain));
        cfg_write(2'd2, cur_offset);
        cfg_write(2'd3, 16'h0000);
        expected_sat = 0;
        send_words(100, 1'b0);
        wait_drain();
        cfg_read(2'd3, rd);
        check_value(rd, expected_sat, "saturation count");
        cfg_write(2'd3, 16'h0000);
        cfg_read(2'd3, rd);
        check_value(rd, 0, "saturation count after clear");
        end_test("saturation_counter");

        drain_random = 1'b0;
        send_words(100, 1'b1);
        wait_drain();
        end_test("full_throughput");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/stream_pkg.sv
src/cfg_pkg.sv
src/fifo2.sv
src/scale_stage.sv
src/scale_cfg.sv
src/stream_scaler_top.sv
bench/stream_scaler_tb.sv
